// ==== Makefile ====
# Verilator build and run of the bus fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_bus_fabric
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/bus_fabric_top.sv ====
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// bus fabric top
// single master request port, decoder, request FIFO and
// slave executor with ram and timer
////////////////////////////////////////////////////////////

module bus_fabric_top
   import bus_map_pkg::*;
(
   input  logic              hclk_i,
   input  logic              arst_n_i,
   // request side
   input  logic              req_valid_i,
   input  logic [ADDR_W-1:0] req_addr_i,
   input  logic              req_write_i,
   input  logic [DATA_W-1:0] req_wdata_i,
   output logic              req_ready_o,
   // response side
   output logic              rsp_valid_o,
   output logic [DATA_W-1:0] rsp_rdata_o,
   output logic              rsp_err_o,
   input  logic              rsp_ready_i,
   output logic              irq_o
);

   req_if dec_to_fifo ();
   req_if fifo_to_exec ();

   req_decoder req_decoder_i (
      .hclk_i      ( hclk_i      ),
      .arst_n_i    ( arst_n_i    ),
      .req_valid_i ( req_valid_i ),
      .req_addr_i  ( req_addr_i  ),
      .req_write_i ( req_write_i ),
      .req_wdata_i ( req_wdata_i ),
      .req_ready_o ( req_ready_o ),
      .req_out     ( dec_to_fifo )
   );

   req_fifo req_fifo_i (
      .hclk_i   ( hclk_i       ),
      .arst_n_i ( arst_n_i     ),
      .push     ( dec_to_fifo  ),
      .pop      ( fifo_to_exec )
   );

   slave_executor slave_executor_i (
      .hclk_i      ( hclk_i       ),
      .arst_n_i    ( arst_n_i     ),
      .req_in      ( fifo_to_exec ),
      .rsp_valid_o ( rsp_valid_o  ),
      .rsp_rdata_o ( rsp_rdata_o  ),
      .rsp_err_o   ( rsp_err_o    ),
      .rsp_ready_i ( rsp_ready_i  ),
      .irq_o       ( irq_o        )
   );

endmodule : bus_fabric_top

// ==== logic/bus_map_pkg.sv ====
////////////////////////////////////////////////////////////
// bus map package
// address map of the fabric, slave select encoding and the
// address and data widths shared by all stages
////////////////////////////////////////////////////////////

package bus_map_pkg;

   ////////////////////////////////////////////////////////////
   // widths

   localparam int ADDR_W    = 32;
   localparam int DATA_W    = 32;

   // word ram size
   localparam int RAM_WORDS = 256;

   ////////////////////////////////////////////////////////////
   // slave regions, base and mask

   localparam logic [ADDR_W-1:0] RAM_BASE   = 32'h2000_0000;
   localparam logic [ADDR_W-1:0] RAM_MASK   = 32'hE000_0000;

   localparam logic [ADDR_W-1:0] TIMER_BASE = 32'h4000_0400;
   localparam logic [ADDR_W-1:0] TIMER_MASK = 32'hFFFF_FFC0; // 16 words

   ////////////////////////////////////////////////////////////
   // slave select

   typedef enum logic [1:0] {
      SLV_RAM   = 2'd0,
      SLV_TIMER = 2'd1,
      SLV_NONE  = 2'd2  // no region hit, answered with error
   } slv_e;

endpackage : bus_map_pkg

// ==== logic/bus_timer.sv ====
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// bus timer
// free running counter with a compare register, sets a
// sticky interrupt flag when the counter hits the compare
////////////////////////////////////////////////////////////

module bus_timer
   import bus_map_pkg::*, bus_xfer_pkg::*;
(
   input  logic              hclk_i,
   input  logic              arst_n_i,
   input  logic              wr_i,
   input  tmr_reg_e          rd_reg_i,
   input  logic [DATA_W-1:0] wdata_i,
   output logic [DATA_W-1:0] rdata_o,
   output logic              irq_o
);

   logic [DATA_W-1:0] count_q;
   logic [DATA_W-1:0] compare_q;

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q   <= '0;
         compare_q <= '1;   // far away from the counter start
         irq_o     <= 1'b0;
      end else begin
         count_q <= count_q + 1'b1;
         if (wr_i && (rd_reg_i == TMR_COMPARE))
            compare_q <= wdata_i;
         // a hit wins over a clear in the same cycle
         if (count_q == compare_q)
            irq_o <= 1'b1;
         else if (wr_i && (rd_reg_i == TMR_STATUS))
            irq_o <= 1'b0;
      end
   end

   always_comb begin
      case (rd_reg_i)
         TMR_COUNT:   rdata_o = count_q;
         TMR_COMPARE: rdata_o = compare_q;
         TMR_STATUS:  rdata_o = {{(DATA_W-1){1'b0}}, irq_o};
         default:     rdata_o = '0;
      endcase
   end

endmodule : bus_timer

// ==== logic/bus_xfer_pkg.sv ====
////////////////////////////////////////////////////////////
// bus transfer package
// opcodes, timer register map and the sizes of the request
// path between decoder, FIFO and executor
////////////////////////////////////////////////////////////

package bus_xfer_pkg;

   // transfer direction
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } op_e;

   // word offset inside a region, covers the whole ram
   localparam int OFFSET_W   = 8;

   // request FIFO slots, also the decoder credit count
   localparam int FIFO_DEPTH = 4;
   localparam int CREDIT_W   = 3;

   ////////////////////////////////////////////////////////////
   // timer registers, word index inside the timer region

   typedef enum logic [1:0] {
      TMR_COUNT   = 2'd0, // read only
      TMR_COMPARE = 2'd1,
      TMR_STATUS  = 2'd2  // read irq flag, write clears it
   } tmr_reg_e;

endpackage : bus_xfer_pkg

// ==== logic/req_decoder.sv ====
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// request decoder
// accepts single word requests from the outside master,
// matches the address against the slave map and registers
// the decoded item towards the request FIFO, one credit each
////////////////////////////////////////////////////////////

module req_decoder
   import bus_map_pkg::*, bus_xfer_pkg::*;
(
   input  logic              hclk_i,
   input  logic              arst_n_i,
   input  logic              req_valid_i,
   input  logic [ADDR_W-1:0] req_addr_i,
   input  logic              req_write_i,
   input  logic [DATA_W-1:0] req_wdata_i,
   output logic              req_ready_o,
   req_if.src                req_out
);

   logic [CREDIT_W-1:0] credit_cnt;
   logic                accept;
   slv_e                sel_d;

   assign req_ready_o = (credit_cnt != '0); // free FIFO slot left
   assign accept      = req_valid_i & req_ready_o;

   ////////////////////////////////////////////////////////////
   // address decode, ram region checked first

   always_comb begin
      if ((req_addr_i & RAM_MASK) == RAM_BASE) begin
         sel_d = SLV_RAM;
      end else if ((req_addr_i & TIMER_MASK) == TIMER_BASE) begin
         sel_d = SLV_TIMER;
      end else begin
         sel_d = SLV_NONE;
      end
   end

   ////////////////////////////////////////////////////////////
   // credits and item valid

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         credit_cnt    <= CREDIT_W'(FIFO_DEPTH);
         req_out.valid <= 1'b0;
      end else begin
         // spend on accept, regain on each returned pulse
         credit_cnt    <= credit_cnt - CREDIT_W'(accept) + CREDIT_W'(req_out.credit);
         req_out.valid <= accept;
      end
   end

   // item fields, captured with the accept
   always_ff @(posedge hclk_i) begin
      if (accept) begin
         req_out.sel    <= sel_d;
         req_out.op     <= req_write_i ? OP_WRITE : OP_READ;
         req_out.offset <= req_addr_i[OFFSET_W+1:2]; // byte to word
         req_out.wdata  <= req_wdata_i;
      end
   end

endmodule : req_decoder

// ==== logic/req_fifo.sv ====
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// request FIFO
// circular store between decoder and executor. pops the
// oldest item while it holds the executor credit and sends
// one credit back to the decoder per pop
////////////////////////////////////////////////////////////

module req_fifo
   import bus_map_pkg::*, bus_xfer_pkg::*;
#(
   parameter int depth = FIFO_DEPTH
) (
   input logic hclk_i,
   input logic arst_n_i,
   req_if.dst  push,
   req_if.src  pop
);

   typedef logic [$clog2(depth)-1:0]   ptr_t;
   typedef logic [$clog2(depth+1)-1:0] cnt_t;

   slv_e                sel_mem    [depth];
   op_e                 op_mem     [depth];
   logic [OFFSET_W-1:0] offset_mem [depth];
   logic [DATA_W-1:0]   wdata_mem  [depth];

   ptr_t wr_ptr;
   ptr_t rd_ptr;
   cnt_t count;
   logic out_credit; // executor response register is free
   logic pop_go;

   // wrap at depth, any depth allowed
   function automatic ptr_t next_ptr(input ptr_t ptr);
      return (ptr == ptr_t'(depth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign pop_go = (count != '0) && out_credit;

   ////////////////////////////////////////////////////////////
   // pointers, fill level and credits

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         out_credit  <= 1'b1;
         pop.valid   <= 1'b0;
         push.credit <= 1'b0;
      end else begin
         if (push.valid)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop_go)
            rd_ptr <= next_ptr(rd_ptr);
         count       <= count + cnt_t'(push.valid) - cnt_t'(pop_go);
         out_credit  <= (out_credit & ~pop_go) | pop.credit;
         pop.valid   <= pop_go;
         push.credit <= pop_go;   // slot freed
      end
   end

   ////////////////////////////////////////////////////////////
   // storage and outgoing item

   always_ff @(posedge hclk_i) begin
      if (push.valid) begin
         sel_mem[wr_ptr]    <= push.sel;
         op_mem[wr_ptr]     <= push.op;
         offset_mem[wr_ptr] <= push.offset;
         wdata_mem[wr_ptr]  <= push.wdata;
      end
      if (pop_go) begin
         pop.sel    <= sel_mem[rd_ptr];
         pop.op     <= op_mem[rd_ptr];
         pop.offset <= offset_mem[rd_ptr];
         pop.wdata  <= wdata_mem[rd_ptr];
      end
   end

endmodule : req_fifo

// ==== logic/req_if.sv ====
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// decoded request link
// one word request per valid pulse, credits flow back
////////////////////////////////////////////////////////////

interface req_if
   import bus_map_pkg::*, bus_xfer_pkg::*;
();

   logic                valid;
   slv_e                sel;
   op_e                 op;
   logic [OFFSET_W-1:0] offset;
   logic [DATA_W-1:0]   wdata;
   logic                credit;  // one pulse per freed slot

   // sending side
   modport src (
      output valid, sel, op, offset, wdata,
      input  credit
   );

   // receiving side
   modport dst (
      input  valid, sel, op, offset, wdata,
      output credit
   );

endinterface : req_if

// ==== logic/slave_executor.sv ====
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// slave executor
// takes popped requests, runs them on the word ram or the
// timer and holds the response until the master takes it
////////////////////////////////////////////////////////////

module slave_executor
   import bus_map_pkg::*, bus_xfer_pkg::*;
(
   input  logic              hclk_i,
   input  logic              arst_n_i,
   req_if.dst                req_in,
   output logic              rsp_valid_o,
   output logic [DATA_W-1:0] rsp_rdata_o,
   output logic              rsp_err_o,
   input  logic              rsp_ready_i,
   output logic              irq_o
);

   logic [DATA_W-1:0] ram [RAM_WORDS];

   logic              rsp_take;
   logic              tmr_hit;
   logic              tmr_wr;
   tmr_reg_e          tmr_reg;
   logic [DATA_W-1:0] tmr_rdata;
   logic [DATA_W-1:0] rdata_d;

   assign rsp_take = rsp_valid_o & rsp_ready_i;

   // only the first four timer words are mapped
   assign tmr_hit = (req_in.sel == SLV_TIMER) && (req_in.offset[OFFSET_W-1:2] == '0);
   assign tmr_wr  = req_in.valid && tmr_hit && (req_in.op == OP_WRITE);
   assign tmr_reg = tmr_reg_e'(req_in.offset[1:0]);

   bus_timer bus_timer_i (
      .hclk_i   ( hclk_i       ),
      .arst_n_i ( arst_n_i     ),
      .wr_i     ( tmr_wr       ),
      .rd_reg_i ( tmr_reg      ),
      .wdata_i  ( req_in.wdata ),
      .rdata_o  ( tmr_rdata    ),
      .irq_o    ( irq_o        )
   );

   ////////////////////////////////////////////////////////////
   // read data select, writes and errors return zero

   always_comb begin
      rdata_d = '0;
      if (req_in.op == OP_READ) begin
         case (req_in.sel)
            SLV_RAM:   rdata_d = ram[req_in.offset];
            SLV_TIMER: rdata_d = tmr_hit ? tmr_rdata : '0;
            default:   rdata_d = '0;
         endcase
      end
   end

   always_ff @(posedge hclk_i) begin
      if (req_in.valid && (req_in.sel == SLV_RAM) && (req_in.op == OP_WRITE))
         ram[req_in.offset] <= req_in.wdata;
      if (req_in.valid) begin
         rsp_rdata_o <= rdata_d;
         rsp_err_o   <= (req_in.sel == SLV_NONE); // unmapped address
      end
   end

   ////////////////////////////////////////////////////////////
   // response handshake

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rsp_valid_o   <= 1'b0;
         req_in.credit <= 1'b0;
      end else begin
         if (req_in.valid)
            rsp_valid_o <= 1'b1;
         else if (rsp_take)
            rsp_valid_o <= 1'b0;
         req_in.credit <= rsp_take;  // response register free again
      end
   end

endmodule : slave_executor

// ==== test/tb_bus_fabric_checks.svh ====
////////////////////////////////////////////////////////////
// bus fabric test sequences
// ram, decode error, back-pressure and timer checks
////////////////////////////////////////////////////////////

`ifndef TB_BUS_FABRIC_CHECKS_SVH
`define TB_BUS_FABRIC_CHECKS_SVH

   task automatic test_ram_round_trip();
      logic [DATA_W-1:0] rdata;
      logic [DATA_W-1:0] wdata;
      logic              err;
      check_value("req_ready_o", 32'h1, 32'(req_ready_o)); // state after reset
      check_value("rsp_valid_o", 32'h0, 32'(rsp_valid_o));
      check_value("irq_o", 32'h0, 32'(irq_o));
      for (int i = 0; i < 16; i++) begin
         wr_off[i] = OFFSET_W'(next_rand());
         wdata     = next_rand();
         ram_model[wr_off[i]] = wdata;
         // upper bits inside the ram region alias to the same word
         do_access(ram_addr(wr_off[i]) | (next_rand() & 32'h1FFF_FC00), 1'b1, wdata,
                   rdata, err);
         check_value("rsp_err_o", 32'h0, 32'(err));
      end
      for (int i = 0; i < 16; i++) begin
         do_access(ram_addr(wr_off[i]), 1'b0, '0, rdata, err);
         check_value("rsp_rdata_o", ram_model[wr_off[i]], rdata);
         check_value("rsp_err_o", 32'h0, 32'(err));
      end
      close_test("ram round trip");
   endtask

   task automatic test_decode_error();
      logic [DATA_W-1:0] rdata;
      logic              err;
      logic [ADDR_W-1:0] bad_addr;
      bad_addr = 32'h6000_0000 | (ADDR_W'(wr_off[0]) << 2); // same word offset as ram
      do_access(bad_addr, 1'b0, '0, rdata, err);
      check_value("rsp_err_o", 32'h1, 32'(err));
      check_value("rsp_rdata_o", 32'h0, rdata);
      do_access(bad_addr, 1'b1, next_rand(), rdata, err);
      check_value("rsp_err_o", 32'h1, 32'(err));
      check_value("rsp_rdata_o", 32'h0, rdata);
      do_access(ram_addr(wr_off[0]), 1'b0, '0, rdata, err);
      check_value("rsp_rdata_o", ram_model[wr_off[0]], rdata);
      check_value("rsp_err_o", 32'h0, 32'(err));
      close_test("decode error");
   endtask

   task automatic test_back_pressure();
      logic [DATA_W-1:0] rdata;
      logic              err;
      logic [DATA_W-1:0] exp_q [$];
      int                n_acc;
      n_acc = 0;
      for (int k = 0; k < 12; k++) begin
         @(negedge hclk_i);
         req_valid_i = 1'b1;
         req_addr_i  = ram_addr(wr_off[n_acc]);
         req_write_i = 1'b0;
         if (req_ready_o) begin  // taken on the next rising edge
            exp_q.push_back(ram_model[wr_off[n_acc]]);
            n_acc++;
         end
      end
      @(negedge hclk_i);
      req_valid_i = 1'b0;
      check_true(n_acc == FIFO_DEPTH + 1,
                 $sformatf("%0d requests accepted under back-pressure, expected %0d",
                           n_acc, FIFO_DEPTH + 1));
      check_value("req_ready_o", 32'h0, 32'(req_ready_o));
      check_value("rsp_valid_o", 32'h1, 32'(rsp_valid_o)); // held, not taken
      while (exp_q.size() > 0) begin
         take_rsp(rdata, err);
         check_value("rsp_rdata_o", exp_q.pop_front(), rdata);
         check_value("rsp_err_o", 32'h0, 32'(err));
      end
      close_test("back-pressure and order");
   endtask

   task automatic test_timer_count();
      logic [DATA_W-1:0] c1;
      logic [DATA_W-1:0] c2;
      logic [DATA_W-1:0] cmp;
      logic              err;
      do_access(tmr_addr(TMR_COUNT), 1'b0, '0, c1, err);
      check_value("rsp_err_o", 32'h0, 32'(err));
      repeat (20) @(negedge hclk_i);
      do_access(tmr_addr(TMR_COUNT), 1'b0, '0, c2, err);
      check_true(c2 > c1, $sformatf("timer count did not increase, %h then %h", c1, c2));
      cmp = next_rand() | 32'h8000_0000; // never reached in this run
      do_access(tmr_addr(TMR_COMPARE), 1'b1, cmp, c1, err);
      do_access(tmr_addr(TMR_COMPARE), 1'b0, '0, c2, err);
      check_value("rsp_rdata_o", cmp, c2);
      close_test("timer count and compare");
   endtask

   task automatic test_timer_irq();
      logic [DATA_W-1:0] rdata;
      logic              err;
      int                n;
      check_value("irq_o", 32'h0, 32'(irq_o));
      do_access(tmr_addr(TMR_COUNT), 1'b0, '0, rdata, err);
      do_access(tmr_addr(TMR_COMPARE), 1'b1, rdata + 32'd200, rdata, err);
      n = 0;
      while (!irq_o && n < 300) begin
         @(negedge hclk_i);
         n++;
      end
      check_true(n >= 150, $sformatf("irq_o set after only %0d cycles", n));
      check_true(irq_o, "irq_o not set within 300 cycles of the compare write");
      do_access(tmr_addr(TMR_STATUS), 1'b0, '0, rdata, err);
      check_value("rsp_rdata_o", 32'h1, rdata);
      do_access(tmr_addr(TMR_STATUS), 1'b1, next_rand(), rdata, err);
      check_value("irq_o", 32'h0, 32'(irq_o)); // cleared by the status write
      close_test("timer interrupt");
   endtask

`endif

// ==== test/tb_bus_fabric.sv ====
`timescale 1ns/10ps
////////////////////////////////////////////////////////////
// bus fabric testbench
// clock, reset, bus master tasks, cycle limit and summary
////////////////////////////////////////////////////////////

module tb_bus_fabric
   import bus_map_pkg::*, bus_xfer_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 3000; // longest test is well under 1000

   logic              hclk_i;
   logic              arst_n_i;
   logic              req_valid_i;
   logic [ADDR_W-1:0] req_addr_i;
   logic              req_write_i;
   logic [DATA_W-1:0] req_wdata_i;
   logic              req_ready_o;
   logic              rsp_valid_o;
   logic [DATA_W-1:0] rsp_rdata_o;
   logic              rsp_err_o;
   logic              rsp_ready_i;
   logic              irq_o;

   logic [31:0]         rng_state = 32'd95;
   logic [DATA_W-1:0]   ram_model [RAM_WORDS]; // last write per offset
   logic [OFFSET_W-1:0] wr_off    [16];
   int                  test_errs = 0;
   int                  pass_cnt  = 0;
   int                  fail_cnt  = 0;
   int                  cycle_cnt = 0;

   bus_fabric_top bus_fabric_top_i (.*);

   initial begin
      hclk_i = 1'b0;
      forever #20 hclk_i = ~hclk_i;
   end

   // run limit
   initial begin
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge hclk_i);
         cycle_cnt++;
      end
      $display("run stopped at the limit of %0d cycles, a handshake never came", cycle_cnt);
      $display("Some tests failed");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [ADDR_W-1:0] ram_addr(input logic [OFFSET_W-1:0] off);
      return RAM_BASE | (ADDR_W'(off) << 2);
   endfunction

   function automatic logic [ADDR_W-1:0] tmr_addr(input tmr_reg_e r);
      return TIMER_BASE | (ADDR_W'(r) << 2);
   endfunction

   ////////////////////////////////////////////////////////////
   // master side, called and left on a falling edge

   task automatic send_req(input logic [ADDR_W-1:0] addr, input logic wr,
                           input logic [DATA_W-1:0] wdata);
      @(negedge hclk_i);
      req_valid_i = 1'b1;
      req_addr_i  = addr;
      req_write_i = wr;
      req_wdata_i = wdata;
      while (!req_ready_o)
         @(negedge hclk_i);
      @(negedge hclk_i);   // accepted on the rising edge before
      req_valid_i = 1'b0;
   endtask

   task automatic take_rsp(output logic [DATA_W-1:0] rdata, output logic err);
      while (!rsp_valid_o)
         @(negedge hclk_i);
      rdata       = rsp_rdata_o;
      err         = rsp_err_o;
      rsp_ready_i = 1'b1;  // one edge only
      @(negedge hclk_i);
      rsp_ready_i = 1'b0;
   endtask

   task automatic do_access(input logic [ADDR_W-1:0] addr, input logic wr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic err);
      send_req(addr, wr, wdata);
      take_rsp(rdata, err);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      assert (got === exp) else begin
         $display("** Error: %s expected %h, got %h", name, exp, got);
         test_errs++;
      end
   endtask

   task automatic check_true(input bit cond, input string what);
      assert (cond) else begin
         $display("%s", what);
         test_errs++;
      end
   endtask

   task automatic close_test(input string name);
      if (test_errs == 0) begin
         pass_cnt++;
         $display("test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("test %s: %0d errors", name, test_errs);
      end
      test_errs = 0;
   endtask

`include "tb_bus_fabric_checks.svh"

   initial begin
      arst_n_i    = 1'b0;
      req_valid_i = 1'b0;
      req_addr_i  = '0;
      req_write_i = 1'b0;
      req_wdata_i = '0;
      rsp_ready_i = 1'b0;
      repeat (3) @(posedge hclk_i);
      @(negedge hclk_i);
      arst_n_i = 1'b1;

      test_ram_round_trip();
      test_decode_error();
      test_back_pressure();
      test_timer_count();
      test_timer_irq();

      $display("summary: %0d tests ok, %0d tests with errors", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule : tb_bus_fabric

// ==== vlog.f ====
+incdir+test
logic/bus_map_pkg.sv
logic/bus_xfer_pkg.sv
logic/req_if.sv
logic/bus_timer.sv
logic/req_decoder.sv
logic/req_fifo.sv
logic/slave_executor.sv
logic/bus_fabric_top.sv
test/tb_bus_fabric.sv
